// ==== verilog/isaPkg.sv ====
package isaPkg;

	////////////////////////////////
	// Register file constants
	////////////////////////////////

	localparam int REG_W = 5;

	// Hardwired zero, never a hazard
	localparam logic [REG_W-1:0] REG_ZERO = 5'd0;
	// Link register written by jal
	localparam logic [REG_W-1:0] REG_RA = 5'd31;

	////////////////////////////////
	// Instruction field positions
	////////////////////////////////

	localparam int OP_MSB    = 31;
	localparam int OP_LSB    = 26;
	localparam int RS_MSB    = 25;
	localparam int RS_LSB    = 21;
	localparam int RT_MSB    = 20;
	localparam int RT_LSB    = 16;
	localparam int RD_MSB    = 15;
	localparam int RD_LSB    = 11;
	localparam int FUNCT_MSB = 5;
	localparam int FUNCT_LSB = 0;

	// Primary opcodes, MIPS encoding
	typedef enum logic [5:0] {
		OP_R    = 6'h00,
		OP_J    = 6'h02,
		OP_JAL  = 6'h03,
		OP_BEQ  = 6'h04,
		OP_ADDI = 6'h08,
		OP_ANDI = 6'h0c,
		OP_ORI  = 6'h0d,
		OP_LUI  = 6'h0f,
		OP_LB   = 6'h20,
		OP_LH   = 6'h21,
		OP_LW   = 6'h23,
		OP_SB   = 6'h28,
		OP_SH   = 6'h29,
		OP_SW   = 6'h2b
	} isaOpcodeE;

	// R-type function codes
	typedef enum logic [5:0] {
		FN_JR    = 6'h08,
		FN_MFHI  = 6'h10,
		FN_MTHI  = 6'h11,
		FN_MFLO  = 6'h12,
		FN_MTLO  = 6'h13,
		FN_MULT  = 6'h18,
		FN_MULTU = 6'h19,
		FN_DIV   = 6'h1a,
		FN_DIVU  = 6'h1b,
		FN_ADD   = 6'h20,
		FN_SUB   = 6'h22,
		FN_AND   = 6'h24,
		FN_OR    = 6'h25,
		FN_SLT   = 6'h2a,
		FN_SLTU  = 6'h2b
	} isaFunctE;

endpackage

// ==== verilog/hazardPkg.sv ====
package hazardPkg;

	import isaPkg::*;

	////////////////////////////////
	// Pipeline timing
	////////////////////////////////

	localparam int TIME_W = 2;

	// Tuse, cycles from D until the operand is consumed
	localparam logic [TIME_W-1:0] TUSE_BRANCH = 2'd0;
	localparam logic [TIME_W-1:0] TUSE_ALU    = 2'd1;
	localparam logic [TIME_W-1:0] TUSE_STORE  = 2'd2;
	// Operand not read at all
	localparam logic [TIME_W-1:0] TUSE_NONE   = 2'd3;

	// Tnew at entry to E
	localparam logic [TIME_W-1:0] TNEW_READY = 2'd0;
	localparam logic [TIME_W-1:0] TNEW_ALU   = 2'd1;
	localparam logic [TIME_W-1:0] TNEW_LOAD  = 2'd2;

	// One instruction in flight that will write a register
	typedef struct packed {
		logic [REG_W-1:0]  dest;
		logic [TIME_W-1:0] tNew;
	} writerRecT;

	// One source operand of the D-stage instruction
	typedef struct packed {
		logic [REG_W-1:0]  src;
		logic [TIME_W-1:0] tUse;
	} operandDemandT;

	// Where a D-stage operand is taken from
	typedef enum logic [1:0] {
		FWD_RF = 2'd0,
		FWD_E  = 2'd1,
		FWD_M  = 2'd2,
		FWD_W  = 2'd3
	} fwdSrcE;

endpackage

// ==== verilog/operandUseDecoder.sv ====
`timescale 1ns/1ps

module operandUseDecoder import isaPkg::*, hazardPkg::*; (
	input  logic [31:0]   instr,
	output operandDemandT demandRs,
	output operandDemandT demandRt
);

	isaOpcodeE        opcode;
	isaFunctE         funct;
	logic [TIME_W-1:0] tUseRs;
	logic [TIME_W-1:0] tUseRt;

	assign opcode = isaOpcodeE'(instr[OP_MSB:OP_LSB]);
	assign funct  = isaFunctE'(instr[FUNCT_MSB:FUNCT_LSB]);

	always_comb begin
		tUseRs = TUSE_NONE;
		tUseRt = TUSE_NONE;
		case (opcode)
			OP_R: begin
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU: begin
						tUseRs = TUSE_ALU;
						tUseRt = TUSE_ALU;
					end
					// Jump target compared in D
					FN_JR: begin
						tUseRs = TUSE_BRANCH;
					end
					// mult/div unit not modelled, hi/lo moves read nothing here
					default: begin
						tUseRs = TUSE_NONE;
						tUseRt = TUSE_NONE;
					end
				endcase
			end

			// Immediate ALU ops, rt is the destination
			OP_ORI, OP_ADDI, OP_ANDI: begin
				tUseRs = TUSE_ALU;
			end

			// Address base is needed in E
			OP_LW, OP_LB, OP_LH: begin
				tUseRs = TUSE_ALU;
			end

			// Store data only needed in M
			OP_SW, OP_SB, OP_SH: begin
				tUseRs = TUSE_ALU;
				tUseRt = TUSE_STORE;
			end

			// Branch compare resolves in D
			OP_BEQ: begin
				tUseRs = TUSE_BRANCH;
				tUseRt = TUSE_BRANCH;
			end

			// lui has no source, j and jal neither
			default: begin
				tUseRs = TUSE_NONE;
				tUseRt = TUSE_NONE;
			end
		endcase
	end

	assign demandRs.src  = instr[RS_MSB:RS_LSB];
	assign demandRs.tUse = tUseRs;
	assign demandRt.src  = instr[RT_MSB:RT_LSB];
	assign demandRt.tUse = tUseRt;

endmodule

// ==== verilog/resultTimingDecoder.sv ====
`timescale 1ns/1ps

module resultTimingDecoder import isaPkg::*, hazardPkg::*; (
	input  logic [31:0] instr,
	output writerRecT   writer
);

	isaOpcodeE         opcode;
	isaFunctE          funct;
	logic [REG_W-1:0]  rt;
	logic [REG_W-1:0]  rd;
	logic [REG_W-1:0]  dest;
	logic [TIME_W-1:0] tNew;

	assign opcode = isaOpcodeE'(instr[OP_MSB:OP_LSB]);
	assign funct  = isaFunctE'(instr[FUNCT_MSB:FUNCT_LSB]);
	assign rt     = instr[RT_MSB:RT_LSB];
	assign rd     = instr[RD_MSB:RD_LSB];

	always_comb begin
		// Defaults cover unknown opcodes, no latch
		dest = REG_ZERO;
		tNew = TNEW_READY;
		case (opcode)
			OP_R: begin
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU: begin
						dest = rd;
						tNew = TNEW_ALU;
					end
					FN_MFHI, FN_MFLO: begin
						dest = rd;
						tNew = TNEW_ALU;
					end
					// hi/lo writers, mult/div unit is outside this block
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO: begin
						dest = REG_ZERO;
						tNew = TNEW_READY;
					end
					FN_JR: begin
						dest = REG_ZERO;
						tNew = TNEW_READY;
					end
					default: begin
						dest = REG_ZERO;
						tNew = TNEW_READY;
					end
				endcase
			end

			OP_ORI, OP_ADDI, OP_ANDI, OP_LUI: begin
				dest = rt;
				tNew = TNEW_ALU;
			end

			// Load data arrives at the end of M
			OP_LW, OP_LB, OP_LH: begin
				dest = rt;
				tNew = TNEW_LOAD;
			end

			// Return address is known when jal enters E
			OP_JAL: begin
				dest = REG_RA;
				tNew = TNEW_READY;
			end

			OP_SW, OP_SB, OP_SH, OP_BEQ, OP_J: begin
				dest = REG_ZERO;
				tNew = TNEW_READY;
			end

			default: begin
				dest = REG_ZERO;
				tNew = TNEW_READY;
			end
		endcase
	end

	// A write to $zero is dropped, so it carries no timing either
	assign writer.dest = dest;
	assign writer.tNew = (dest == REG_ZERO) ? TNEW_READY : tNew;

endmodule

// ==== verilog/writerPipeline.sv ====
`timescale 1ns/1ps

module writerPipeline import isaPkg::*, hazardPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      stall,
	input  writerRecT newWriter,
	output writerRecT recE,
	output writerRecT recM,
	output writerRecT recW
);

	// One stage of ageing, Tnew saturates at zero
	function automatic writerRecT ageRec(input writerRecT rec);
		writerRecT aged;
		aged = rec;
		if (rec.tNew != '0) begin
			aged.tNew = rec.tNew - 1'b1;
		end
		return aged;
	endfunction

	////////////////////////////////
	// Record shift register
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			recE <= '0;
			recM <= '0;
			recW <= '0;
		end else begin
			// Bubble into E while D is held
			if (stall) begin
				recE <= '0;
			end else begin
				recE <= newWriter;
			end
			recM <= ageRec(recE);
			recW <= ageRec(recM);
		end
	end

	////////////////////////////////
	// Checks
	////////////////////////////////

	// Largest Tnew at E is 2, so two agings always leave zero in W
	aWRecReady: assert property (
		@(posedge clk) disable iff (reset)
		recW.tNew == '0
	);

	// Empty records stay empty through every stage
	aZeroDestIdle: assert property (
		@(posedge clk) disable iff (reset)
		(recE.dest != REG_ZERO || recE.tNew == '0) &&
		(recM.dest != REG_ZERO || recM.tNew == '0) &&
		(recW.dest != REG_ZERO || recW.tNew == '0)
	);

endmodule

// ==== verilog/hazardResolver.sv ====
`timescale 1ns/1ps

module hazardResolver import isaPkg::*, hazardPkg::*; (
	input  logic          clk,
	input  operandDemandT demandRs,
	input  operandDemandT demandRt,
	input  writerRecT     recE,
	input  writerRecT     recM,
	input  writerRecT     recW,
	output logic          stall,
	output fwdSrcE        fwdRs,
	output fwdSrcE        fwdRt
);

	logic stallRs;
	logic stallRt;

	// Youngest matching writer decides, E before M before W
	function automatic void resolveOperand(
		input  operandDemandT demand,
		input  writerRecT     e,
		input  writerRecT     m,
		input  writerRecT     w,
		output logic          needStall,
		output fwdSrcE        fwd
	);
		writerRecT hit;
		fwdSrcE    stage;
		logic      found;
		needStall = 1'b0;
		fwd       = FWD_RF;
		hit       = '0;
		stage     = FWD_RF;
		found     = 1'b0;
		if (demand.src != REG_ZERO && demand.tUse != TUSE_NONE) begin
			if (e.dest == demand.src) begin
				hit   = e;
				stage = FWD_E;
				found = 1'b1;
			end else if (m.dest == demand.src) begin
				hit   = m;
				stage = FWD_M;
				found = 1'b1;
			end else if (w.dest == demand.src) begin
				hit   = w;
				stage = FWD_W;
				found = 1'b1;
			end
		end
		if (found) begin
			if (hit.tNew > demand.tUse) begin
				needStall = 1'b1;
			end else if (hit.tNew == '0) begin
				fwd = stage;
			end
			// Result not ready yet but in time, picked up at a later stage
		end
	endfunction

	always_comb begin
		resolveOperand(demandRs, recE, recM, recW, stallRs, fwdRs);
		resolveOperand(demandRt, recE, recM, recW, stallRt, fwdRt);
	end

	assign stall = stallRs | stallRt;

	// Tnew of the stage a forward select points at
	function automatic logic [TIME_W-1:0] stageTnew(input fwdSrcE sel);
		case (sel)
			FWD_E:   return recE.tNew;
			FWD_M:   return recM.tNew;
			FWD_W:   return recW.tNew;
			default: return '0;
		endcase
	endfunction

	// Forwarded value must already exist in the selected stage
	aFwdReady: assert property (
		@(posedge clk)
		stageTnew(fwdRs) == '0 && stageTnew(fwdRt) == '0
	);

endmodule

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import hazardPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] instrD,
	output logic        stall,
	output fwdSrcE      fwdRs,
	output fwdSrcE      fwdRt
);

	operandDemandT demandRs;
	operandDemandT demandRt;
	writerRecT     newWriter;
	writerRecT     recE;
	writerRecT     recM;
	writerRecT     recW;

	// Demands of the instruction sitting in D
	operandUseDecoder operandUseDecoder_i (
		.instr    (instrD),
		.demandRs (demandRs),
		.demandRt (demandRt)
	);

	// Record it will carry into E
	resultTimingDecoder resultTimingDecoder_i (
		.instr  (instrD),
		.writer (newWriter)
	);

	writerPipeline writerPipeline_i (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.newWriter (newWriter),
		.recE      (recE),
		.recM      (recM),
		.recW      (recW)
	);

	hazardResolver hazardResolver_i (
		.clk      (clk),
		.demandRs (demandRs),
		.demandRt (demandRt),
		.recE     (recE),
		.recM     (recM),
		.recW     (recW),
		.stall    (stall),
		.fwdRs    (fwdRs),
		.fwdRt    (fwdRt)
	);

endmodule

// ==== dv/hazardUnitTb.sv ====
`timescale 1ns/1ps

module hazardUnitTb import isaPkg::*, hazardPkg::*; ();

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_RANDOM   = 30;
	localparam int LONG_RANDOM  = 200;
	// Upper bound on directed and drain instructions over all tests
	localparam int DIRECTED_MAX = 80;
	// An instruction spends at most three cycles in D (two stalls after a load)
	localparam int TEST_CYCLES  =
		RESET_CYCLES + 3 * (5 * NUM_RANDOM + LONG_RANDOM + DIRECTED_MAX);
	localparam logic [31:0] LFSR_SEED = 32'h4996_48db;
	localparam logic [31:0] NOP       = 32'h0000_0000;

	typedef struct packed {
		logic   stl;
		fwdSrcE fwd;
	} expectT;

	logic        clk;
	logic        reset;
	logic [31:0] instrD;
	logic        stall;
	fwdSrcE      fwdRs;
	fwdSrcE      fwdRt;

	logic [31:0] lfsrState;
	writerRecT   modelRec [3];
	expectT      expRs;
	expectT      expRt;
	logic        expStall;
	int          errorCount = 0;
	int          testCount  = 0;
	int          failCount  = 0;
	int          testErrors;
	int          stallSeen  = 0;
	int          fwdESeen   = 0;
	int          fwdMSeen   = 0;
	int          fwdAnySeen = 0;
	int          snapStall;
	int          snapFwdE;
	int          snapFwdM;
	int          snapFwdAny;

	hazardUnit dut_i (
		.clk    (clk),
		.reset  (reset),
		.instrD (instrD),
		.stall  (stall),
		.fwdRs  (fwdRs),
		.fwdRt  (fwdRt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		// Taps 32, 22, 2, 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] encodeR(input isaFunctE fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input isaOpcodeE op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Registers 0 to 3 only, so producers and consumers collide often
	function automatic logic [31:0] randomInstr();
		logic [3:0]  pick;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [31:0] instr;
		pick = 4'(takeBits(4));
		rs   = 5'(takeBits(2));
		rt   = 5'(takeBits(2));
		rd   = 5'(takeBits(2));
		case (pick)
			4'd0:    instr = encodeR(FN_ADD, rs, rt, rd);
			4'd1:    instr = encodeR(FN_SUB, rs, rt, rd);
			4'd2:    instr = encodeR(FN_OR, rs, rt, rd);
			4'd3:    instr = encodeR(FN_SLT, rs, rt, rd);
			4'd4:    instr = encodeI(OP_ORI, rs, rt, 16'h00ff);
			4'd5:    instr = encodeI(OP_ADDI, rs, rt, 16'h0004);
			4'd6:    instr = encodeI(OP_LUI, REG_ZERO, rt, 16'h1234);
			4'd7:    instr = encodeI(OP_LW, rs, rt, 16'h0000);
			4'd8:    instr = encodeI(OP_LH, rs, rt, 16'h0002);
			4'd9:    instr = encodeI(OP_SW, rs, rt, 16'h0000);
			4'd10:   instr = encodeI(OP_SB, rs, rt, 16'h0001);
			4'd11:   instr = encodeI(OP_BEQ, rs, rt, 16'h0010);
			4'd12:   instr = {OP_JAL, 26'h0000040};
			4'd13:   instr = encodeR(FN_JR, (rs == REG_ZERO) ? REG_RA : rs, 5'd0, 5'd0);
			4'd14:   instr = encodeR(FN_MULT, rs, rt, 5'd0);
			default: instr = encodeR(FN_MFHI, 5'd0, 5'd0, rd);
		endcase
		return instr;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic isAluFunct(input logic [5:0] fn);
		return fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU};
	endfunction

	// Cycles from D until the operand is needed
	function automatic logic [TIME_W-1:0] readTime(input logic [31:0] instr,
		input logic forRt);
		logic [5:0]        op;
		logic [5:0]        fn;
		logic [TIME_W-1:0] rsTime;
		logic [TIME_W-1:0] rtTime;
		op     = instr[OP_MSB:OP_LSB];
		fn     = instr[FUNCT_MSB:FUNCT_LSB];
		rsTime = TUSE_NONE;
		rtTime = TUSE_NONE;
		if (op == OP_BEQ) begin
			rsTime = 2'd0;
			rtTime = 2'd0;
		end else if (op == OP_R && fn == FN_JR) begin
			rsTime = 2'd0;
		end else if (op == OP_R && isAluFunct(fn)) begin
			rsTime = 2'd1;
			rtTime = 2'd1;
		end else if (op inside {OP_ORI, OP_ADDI, OP_ANDI, OP_LW, OP_LB, OP_LH}) begin
			rsTime = 2'd1;
		end else if (op inside {OP_SW, OP_SB, OP_SH}) begin
			rsTime = 2'd1;
			rtTime = 2'd2;
		end
		return forRt ? rtTime : rsTime;
	endfunction

	function automatic writerRecT expectWriter(input logic [31:0] instr);
		logic [5:0] op;
		logic [5:0] fn;
		writerRecT  rec;
		op  = instr[OP_MSB:OP_LSB];
		fn  = instr[FUNCT_MSB:FUNCT_LSB];
		rec = '0;
		if (op == OP_R && (isAluFunct(fn) || fn == FN_MFHI || fn == FN_MFLO)) begin
			rec.dest = instr[RD_MSB:RD_LSB];
			rec.tNew = 2'd1;
		end else if (op inside {OP_ORI, OP_ADDI, OP_ANDI, OP_LUI}) begin
			rec.dest = instr[RT_MSB:RT_LSB];
			rec.tNew = 2'd1;
		end else if (op inside {OP_LW, OP_LB, OP_LH}) begin
			rec.dest = instr[RT_MSB:RT_LSB];
			rec.tNew = 2'd2;
		end else if (op == OP_JAL) begin
			rec.dest = REG_RA;
		end
		if (rec.dest == REG_ZERO) begin
			rec.tNew = '0;
		end
		return rec;
	endfunction

	function automatic writerRecT ageRecord(input writerRecT rec);
		writerRecT aged;
		aged = rec;
		if (aged.tNew != 2'd0) begin
			aged.tNew = aged.tNew - 2'd1;
		end
		return aged;
	endfunction

	// Index 0 is E, so the first hit is the youngest writer
	function automatic expectT expectOperand(input logic [4:0] src,
		input logic [TIME_W-1:0] tUse, input writerRecT e, input writerRecT m,
		input writerRecT w);
		writerRecT recs [3];
		expectT    res;
		logic      done;
		int        i;
		recs[0] = e;
		recs[1] = m;
		recs[2] = w;
		res.stl = 1'b0;
		res.fwd = FWD_RF;
		done    = 1'b0;
		if (src != REG_ZERO && tUse != TUSE_NONE) begin
			for (i = 0; i < 3; i++) begin
				if (!done && recs[i].dest == src) begin
					done = 1'b1;
					if (recs[i].tNew > tUse) begin
						res.stl = 1'b1;
					end else if (recs[i].tNew == 2'd0) begin
						res.fwd = fwdSrcE'(i + 1);
					end
				end
			end
		end
		return res;
	endfunction

	always_comb begin
		expRs = expectOperand(instrD[RS_MSB:RS_LSB], readTime(instrD, 1'b0),
			modelRec[0], modelRec[1], modelRec[2]);
		expRt = expectOperand(instrD[RT_MSB:RT_LSB], readTime(instrD, 1'b1),
			modelRec[0], modelRec[1], modelRec[2]);
		expStall = expRs.stl | expRt.stl;
	end

	always @(posedge clk) begin
		if (reset) begin
			modelRec[0] <= '0;
			modelRec[1] <= '0;
			modelRec[2] <= '0;
		end else begin
			modelRec[0] <= expStall ? '0 : expectWriter(instrD);
			modelRec[1] <= ageRecord(modelRec[0]);
			modelRec[2] <= ageRecord(modelRec[1]);
		end
	end

	// Event counters for the directed checks
	always @(posedge clk) begin
		if (!reset) begin
			if (stall) stallSeen <= stallSeen + 1;
			if (fwdRs == FWD_E || fwdRt == FWD_E) fwdESeen <= fwdESeen + 1;
			if (fwdRs == FWD_M || fwdRt == FWD_M) fwdMSeen <= fwdMSeen + 1;
			if (fwdRs != FWD_RF || fwdRt != FWD_RF) fwdAnySeen <= fwdAnySeen + 1;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic reportMismatch(input string sig, input int got, input int exp);
		errorCount++;
		$display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, sig, got, exp);
	endtask

	stallMatches: assert property (@(posedge clk) disable iff (reset) stall == expStall)
		else reportMismatch("stall", int'($sampled(stall)), int'($sampled(expStall)));

	fwdRsMatches: assert property (@(posedge clk) disable iff (reset) fwdRs == expRs.fwd)
		else reportMismatch("fwdRs", int'($sampled(fwdRs)), int'($sampled(expRs.fwd)));

	fwdRtMatches: assert property (@(posedge clk) disable iff (reset) fwdRt == expRt.fwd)
		else reportMismatch("fwdRt", int'($sampled(fwdRt)), int'($sampled(expRt.fwd)));

	idleAfterReset: assert property (@(posedge clk)
		$fell(reset) |-> !stall && fwdRs == FWD_RF && fwdRt == FWD_RF)
		else begin
			errorCount++;
			$display("At %0t the unit was not idle right after reset", $time);
		end

	task automatic expectCount(input string what, input int got, input int exp);
		assert (got == exp) else reportMismatch(what, got, exp);
	endtask

	//////////////////////////////
	// Test sequencing
	//////////////////////////////

	// Holds the instruction in D until stall is low at a rising edge
	task automatic issue(input logic [31:0] instr);
		instrD <= instr;
		@(posedge clk);
		while (stall) @(posedge clk);
	endtask

	task automatic drain();
		repeat (3) issue(NOP);
	endtask

	task automatic snapshot();
		snapStall  = stallSeen;
		snapFwdE   = fwdESeen;
		snapFwdM   = fwdMSeen;
		snapFwdAny = fwdAnySeen;
	endtask

	task automatic startTest();
		testErrors = errorCount;
		snapshot();
	endtask

	task automatic finishTest(input string name, input int numRandom);
		repeat (numRandom) issue(randomInstr());
		drain();
		testCount++;
		if (errorCount != testErrors) begin
			failCount++;
		end
		$display("Test %0d %s: %s (%0d errors)", testCount, name,
			(errorCount == testErrors) ? "pass" : "FAIL", errorCount - testErrors);
	endtask

	initial begin
		reset     = 1'b1;
		// Load to $1 sits in D through reset, a record leaking past reset stalls the beq
		instrD    = encodeI(OP_LW, 5'd2, 5'd1, 16'h0000);
		lfsrState = LFSR_SEED;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		startTest();
		issue(encodeI(OP_BEQ, 5'd1, 5'd1, 16'h0004));
		drain();
		finishTest("resetIdle", NUM_RANDOM);

		// lw $1,0($2) then add $3,$1,$2
		startTest();
		issue(encodeI(OP_LW, 5'd2, 5'd1, 16'h0000));
		issue(encodeR(FN_ADD, 5'd1, 5'd2, 5'd3));
		drain();
		// Forward from the load happens past D, outside this unit
		expectCount("load use stall cycles", stallSeen - snapStall, 1);
		finishTest("loadUse", NUM_RANDOM);

		startTest();
		issue(encodeR(FN_ADD, 5'd2, 5'd3, 5'd1));
		issue(encodeR(FN_ADD, 5'd1, 5'd2, 5'd3));
		drain();
		expectCount("alu use stall cycles", stallSeen - snapStall, 0);
		snapshot();
		issue(encodeR(FN_ADD, 5'd2, 5'd3, 5'd1));
		issue(encodeI(OP_BEQ, 5'd1, 5'd0, 16'h0008));
		drain();
		expectCount("branch use stall cycles", stallSeen - snapStall, 1);
		expectCount("branch fwd from M cycles", fwdMSeen - snapFwdM, 1);
		finishTest("aluUse", NUM_RANDOM);

		startTest();
		issue({OP_JAL, 26'h0000100});
		issue(encodeR(FN_JR, REG_RA, 5'd0, 5'd0));
		drain();
		expectCount("jal jr stall cycles", stallSeen - snapStall, 0);
		expectCount("jal jr fwd from E cycles", fwdESeen - snapFwdE, 1);
		finishTest("jalJr", NUM_RANDOM);

		// Nothing here writes a nonzero register
		startTest();
		issue(encodeR(FN_ADD, 5'd1, 5'd2, 5'd0));
		issue(encodeR(FN_ADD, 5'd0, 5'd0, 5'd0));
		issue(encodeI(OP_SW, 5'd2, 5'd1, 16'h0000));
		issue(encodeR(FN_ADD, 5'd1, 5'd2, 5'd0));
		issue(encodeR(FN_MULT, 5'd1, 5'd2, 5'd0));
		issue(encodeR(FN_ADD, 5'd1, 5'd2, 5'd0));
		issue({OP_J, 26'h0000200});
		// Plain j must not leave a link in $31
		issue(encodeR(FN_JR, REG_RA, 5'd0, 5'd0));
		drain();
		expectCount("no writer stall cycles", stallSeen - snapStall, 0);
		expectCount("no writer fwd cycles", fwdAnySeen - snapFwdAny, 0);
		finishTest("noWriter", NUM_RANDOM);

		startTest();
		finishTest("randomStream", LONG_RANDOM);

		$display("Tests run %0d, failed %0d, errors %0d", testCount, failCount, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", 2 * TEST_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== src.f ====
verilog/isaPkg.sv
verilog/hazardPkg.sv
verilog/operandUseDecoder.sv
verilog/resultTimingDecoder.sv
verilog/writerPipeline.sv
verilog/hazardResolver.sv
verilog/hazardUnit.sv
dv/hazardUnitTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module hazardUnitTb -o simv
out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
	exit 0
fi
exit 1
